// File: sim.f
+incdir+source
+incdir+tests
source/ll_frame_pkg.sv
source/copy_job_pkg.sv
source/sync_fifo.sv
source/payload_crc.sv
source/tx_frame_parser.sv
source/rx_frame_builder.sv
source/copy_unit.sv
tests/tb_copy_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the copy unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_copy_unit -f sim.f
./obj_dir/Vtb_copy_unit

// File: tests/tb_copy_model.svh
`ifndef TB_COPY_MODEL_SVH
`define TB_COPY_MODEL_SVH

// Expected output beats, oldest first
ll_beat_t exp_q[$];

function automatic int byte_count_of(input logic [3:0] rem);
   if (rem == 4'b0001) return 3;
   if (rem == 4'b0011) return 2;
   if (rem == 4'b0111) return 1;
   return 4;
endfunction

// Reference CRC-32 over one word, MSB first, low bytes past nbytes zeroed
function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [31:0] word,
                                         input int nbytes);
   logic [31:0] d;
   logic [31:0] c;
   logic        fb;
   d = word;
   c = crc;
   for (int b = nbytes; b < 4; b++) begin
      d[8*(3-b) +: 8] = 8'h00;
   end
   for (int i = 31; i >= 0; i--) begin
      fb = c[31] ^ d[i];
      c = {c[30:0], 1'b0};
      if (fb) begin
         c = c ^ `CRC_POLY;
      end
   end
   return c;
endfunction

task automatic push_status(input logic [31:0] word, input logic last);
   ll_beat_t b;
   b = '0;
   b.data = word;
   b.eof = last;
   exp_q.push_back(b);
endtask

// One frame: payload copied, then the four completion words
task automatic model_frame(input logic [31:0] words[$], input logic [3:0] last_rem,
                           input logic [2:0] flags, input logic [31:0] len_field,
                           input logic [9:0] task_idx);
   ll_beat_t    b;
   logic [31:0] crc;
   int          nbytes;
   crc = `CRC_INIT;
   nbytes = 0;
   for (int i = 0; i < words.size(); i++) begin
      b = '0;
      b.data = words[i];
      b.sof = (i == 0);
      b.sop = (i == 0);
      b.eop = (i == words.size() - 1);
      b.rem = b.eop ? last_rem : 4'b0000;
      nbytes += byte_count_of(b.rem);
      crc = crc_next(crc, words[i], byte_count_of(b.rem));
      exp_q.push_back(b);
   end
   push_status({flags, (nbytes != len_field), 17'd0, 1'b1, crc[9:0]}, 1'b0);
   push_status(nbytes, 1'b0);
   push_status({crc[31:10], task_idx}, 1'b0);
   push_status(crc, 1'b1);
endtask

`endif

// File: tests/tb_copy_unit.sv
`timescale 1ns/100ps
`include "copy_params.svh"

module tb_copy_unit
   import ll_frame_pkg::*;
();
   logic     clk = 1'b0;
   logic     rst_n;
   ll_beat_t in_beat;
   logic     in_valid;
   logic     in_ready;
   ll_beat_t out_beat;
   logic     out_valid;
   logic     out_ready = 1'b0;
   integer   seed = 81;
   string    test_name = "reset";
   bit       hold_out = 1'b1;
   bit       stall_out = 1'b0;

`include "tb_copy_model.svh"

   always #20 clk = ~clk;

   copy_unit DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_beat_o  (out_beat),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   // Output sink with optional random stalls
   always @(posedge clk) begin
      #2;
      if (hold_out) begin
         out_ready = 1'b0;
      end else if (stall_out) begin
         out_ready = ($random(seed) % 3) != 0;
      end else begin
         out_ready = 1'b1;
      end
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         report_failure($sformatf("[FAIL] %s %s expected %h actual %h",
                                  test_name, what, expected, actual));
      end
   endtask

   // Scoreboard for transferred output beats
   always @(negedge clk) begin
      ll_beat_t expected_beat;
      if (rst_n === 1'b1 && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            report_failure("Output beat arrived while no frame was expected");
         end else begin
            expected_beat = exp_q.pop_front();
            check_value("beat data", expected_beat.data, out_beat.data);
            check_value("beat rem/sof/eof/sop/eop",
                        32'({expected_beat.rem, expected_beat.sof, expected_beat.eof,
                             expected_beat.sop, expected_beat.eop}),
                        32'({out_beat.rem, out_beat.sof, out_beat.eof,
                             out_beat.sop, out_beat.eop}));
         end
      end
   end

   // Beat and valid are held until the DUT takes the beat
   task automatic drive_beat(input ll_beat_t beat, input bit gaps);
      int waited;
      waited = 0;
      if (gaps && ($random(seed) % 4) == 0) begin
         in_valid = 1'b0;
         @(posedge clk);
         #2;
      end
      in_beat = beat;
      in_valid = 1'b1;
      while (in_ready !== 1'b1) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > 2000) begin
            report_failure("Timeout waiting for in_ready on an input beat");
         end
      end
      @(posedge clk);
      #2;
   endtask

   task automatic send_frame(input bit gaps);
      logic [31:0] words[$];
      logic [3:0]  last_rem;
      logic [2:0]  flags;
      logic [9:0]  task_idx;
      logic [31:0] len_field;
      int          nwords;
      ll_beat_t    beat;
      nwords = 1 + ($unsigned($random(seed)) % 12);
      for (int i = 0; i < nwords; i++) begin
         words.push_back($random(seed));
      end
      case ($unsigned($random(seed)) % 4)
         0: last_rem = 4'b0000;
         1: last_rem = 4'b0001;
         2: last_rem = 4'b0011;
         default: last_rem = 4'b0111;
      endcase
      flags = 3'($random(seed));
      task_idx = 10'($random(seed));
      len_field = 4 * (nwords - 1) + byte_count_of(last_rem);
      // Roughly one frame in four carries a wrong length
      if (($random(seed) % 4) == 0) begin
         len_field = len_field + 1 + ($unsigned($random(seed)) % 64);
      end
      model_frame(words, last_rem, flags, len_field, task_idx);
      for (int h = 0; h < `HDR_WORDS; h++) begin
         beat = '0;
         beat.data = $random(seed);
         if (h == 4) beat.data[31:29] = flags;
         if (h == 5) beat.data = len_field;
         if (h == 6) beat.data[9:0] = task_idx;
         beat.sof = (h == 0);
         drive_beat(beat, gaps);
      end
      for (int i = 0; i < nwords; i++) begin
         beat = '0;
         beat.data = words[i];
         beat.sop = (i == 0);
         beat.eop = (i == nwords - 1);
         beat.eof = beat.eop;
         beat.rem = beat.eop ? last_rem : 4'b0000;
         drive_beat(beat, gaps);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > 5000) begin
            report_failure("Timeout waiting for the expected output frames");
         end
      end
   endtask

   initial begin
      int waited;
      int low_run;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_beat = '0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_value("out_valid after reset", 32'd0, 32'(out_valid));
      check_value("in_ready after reset", 32'd1, 32'(in_ready));

      test_name = "random_frames";
      hold_out = 1'b0;
      stall_out = 1'b1;
      for (int f = 0; f < 40; f++) begin
         send_frame(1'b1);
      end
      in_valid = 1'b0;
      wait_drain();

      test_name = "backpressure";
      stall_out = 1'b0;
      hold_out = 1'b1;
      fork
         begin
            for (int f = 0; f < 10; f++) begin
               send_frame(1'b0);
            end
            in_valid = 1'b0;
         end
         begin
            low_run = 0;
            waited = 0;
            // Input stalled for several cycles means the FIFOs are full
            while (low_run < 8) begin
               @(negedge clk);
               waited++;
               low_run = (in_valid && !in_ready) ? low_run + 1 : 0;
               if (waited > 2000) begin
                  report_failure("in_ready never dropped while the output was held");
               end
            end
            hold_out = 1'b0;
         end
      join
      wait_drain();

      $display("all tests passed");
      $finish;
   end

endmodule

// File: source/copy_unit.sv
`timescale 1ns/100ps
`include "copy_params.svh"

module copy_unit
   import ll_frame_pkg::*;
   import copy_job_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  ll_beat_t in_beat_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output ll_beat_t out_beat_o,
   output logic     out_valid_o,
   input  logic     out_ready_i
);
   logic               beat_push;
   ll_beat_t           beat_wdata;
   logic               beat_full;
   logic               beat_pop;
   ll_beat_t           beat_rdata;
   logic               beat_empty;
   logic               job_push;
   copy_job_t          job_wdata;
   logic               job_full;
   logic               job_pop;
   copy_job_t          job_rdata;
   logic               job_empty;
   logic               crc_clear;
   logic               crc_enable;
   logic [`DATA_W-1:0] crc_val;

   tx_frame_parser u_parser (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_beat_i    (in_beat_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .beat_push_o  (beat_push),
      .beat_data_o  (beat_wdata),
      .beat_full_i  (beat_full),
      .job_push_o   (job_push),
      .job_data_o   (job_wdata),
      .job_full_i   (job_full),
      .crc_clear_o  (crc_clear),
      .crc_enable_o (crc_enable),
      .crc_i        (crc_val)
   );

   // Only the last payload word is partial
   payload_crc u_crc (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear_i  (crc_clear),
      .enable_i (crc_enable),
      .word_i   (beat_wdata.data),
      .rem_i    (beat_wdata.eop ? beat_wdata.rem : REM_FULL),
      .crc_o    (crc_val)
   );

   sync_fifo #(
      .item_t (ll_beat_t),
      .DEPTH  (`BEAT_FIFO_DEPTH)
   ) u_beat_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_i      (beat_push),
      .push_data_i (beat_wdata),
      .full_o      (beat_full),
      .pop_i       (beat_pop),
      .pop_data_o  (beat_rdata),
      .empty_o     (beat_empty)
   );

   sync_fifo #(
      .item_t (copy_job_t),
      .DEPTH  (`JOB_FIFO_DEPTH)
   ) u_job_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_i      (job_push),
      .push_data_i (job_wdata),
      .full_o      (job_full),
      .pop_i       (job_pop),
      .pop_data_o  (job_rdata),
      .empty_o     (job_empty)
   );

   rx_frame_builder u_builder (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_pop_o   (beat_pop),
      .beat_data_i  (beat_rdata),
      .beat_empty_i (beat_empty),
      .job_pop_o    (job_pop),
      .job_data_i   (job_rdata),
      .job_empty_i  (job_empty),
      .out_beat_o   (out_beat_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i)
   );

endmodule

// File: source/rx_frame_builder.sv
`timescale 1ns/100ps
`include "copy_params.svh"

module rx_frame_builder
   import ll_frame_pkg::*;
   import copy_job_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   output logic      beat_pop_o,
   input  ll_beat_t  beat_data_i,
   input  logic      beat_empty_i,
   output logic      job_pop_o,
   input  copy_job_t job_data_i,
   input  logic      job_empty_i,
   output ll_beat_t  out_beat_o,
   output logic      out_valid_o,
   input  logic      out_ready_i
);
   localparam int ST_IDX_W = $clog2(`STATUS_WORDS);

   typedef enum logic {
      PH_PAYLOAD,
      PH_STATUS
   } phase_t;

   phase_t              phase;
   logic [ST_IDX_W-1:0] st_idx;
   ll_beat_t            out_q;
   logic                out_valid_q;
   logic                load_en;
   logic                status_load;
   logic                st_last;
   status1_t            status1;
   status3_t            status3;
   logic [`DATA_W-1:0]  status_word;

   // Output register is free or drains this cycle
   assign load_en     = !out_valid_q || out_ready_i;
   assign beat_pop_o  = load_en && (phase == PH_PAYLOAD) && !beat_empty_i;
   assign status_load = load_en && (phase == PH_STATUS) && !job_empty_i;
   assign st_last     = (st_idx == ST_IDX_W'(`STATUS_WORDS - 1));
   assign job_pop_o   = status_load && st_last;

   always_comb begin
      status1           = '0;
      status1.flags     = job_data_i.flags;
      status1.len_err   = (job_data_i.byte_cnt != job_data_i.len_field);
      status1.crc_valid = 1'b1;
      status1.crc_lo    = job_data_i.crc[9:0];
      status3.crc_hi    = job_data_i.crc[`DATA_W-1:`TASK_W];
      status3.task_idx  = job_data_i.task_idx;
   end

   always_comb begin
      case (st_idx)
         2'd0:    status_word = status1;
         2'd1:    status_word = job_data_i.byte_cnt;
         2'd2:    status_word = status3;
         default: status_word = job_data_i.crc;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase       <= PH_PAYLOAD;
         st_idx      <= '0;
         out_valid_q <= 1'b0;
      end else if (load_en) begin
         out_valid_q <= beat_pop_o || status_load;
         if (beat_pop_o && beat_data_i.eop) begin
            phase <= PH_STATUS;
         end
         if (status_load) begin
            if (st_last) begin
               st_idx <= '0;
               phase  <= PH_PAYLOAD;
            end else begin
               st_idx <= st_idx + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (beat_pop_o) begin
         out_q     <= beat_data_i;
         // First payload beat also opens the frame
         out_q.sof <= beat_data_i.sop;
      end else if (status_load) begin
         out_q.data <= status_word;
         out_q.rem  <= REM_FULL;
         out_q.sof  <= 1'b0;
         out_q.eof  <= st_last;
         out_q.sop  <= 1'b0;
         out_q.eop  <= 1'b0;
      end
   end

   assign out_beat_o  = out_q;
   assign out_valid_o = out_valid_q;

endmodule

// File: source/tx_frame_parser.sv
`timescale 1ns/100ps
`include "copy_params.svh"

module tx_frame_parser
   import ll_frame_pkg::*;
   import copy_job_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  ll_beat_t           in_beat_i,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   output logic               beat_push_o,
   output ll_beat_t           beat_data_o,
   input  logic               beat_full_i,
   output logic               job_push_o,
   output copy_job_t          job_data_o,
   input  logic               job_full_i,
   output logic               crc_clear_o,
   output logic               crc_enable_o,
   input  logic [`DATA_W-1:0] crc_i
);
   localparam int HDR_CNT_W = $clog2(`HDR_WORDS);

   typedef enum logic [1:0] {
      ST_HDR,
      ST_PAYLOAD,
      ST_DESC
   } state_t;

   state_t                 state;
   logic [HDR_CNT_W-1:0]   hdr_cnt;
   op_flags_t              flags_q;
   logic [`DATA_W-1:0]     len_q;
   logic [`TASK_W-1:0]     task_q;
   logic [`DATA_W-1:0]     byte_cnt;
   logic                   in_fire;
   hdr_flags_word_t        flags_word;
   hdr_task_word_t         task_word;

   assign flags_word = hdr_flags_word_t'(in_beat_i.data);
   assign task_word  = hdr_task_word_t'(in_beat_i.data);

   always_comb begin
      case (state)
         ST_HDR:     in_ready_o = 1'b1;
         ST_PAYLOAD: in_ready_o = !beat_full_i;
         default:    in_ready_o = 1'b0;
      endcase
   end

   assign in_fire      = in_valid_i && in_ready_o;
   assign beat_push_o  = in_fire && (state == ST_PAYLOAD);
   assign crc_clear_o  = (state == ST_HDR);
   assign crc_enable_o = beat_push_o;
   assign job_push_o   = (state == ST_DESC);

   // Frame flags are regenerated on the output side
   always_comb begin
      beat_data_o     = in_beat_i;
      beat_data_o.sof = 1'b0;
      beat_data_o.eof = 1'b0;
   end

   always_comb begin
      job_data_o.flags     = flags_q;
      job_data_o.len_field = len_q;
      job_data_o.task_idx  = task_q;
      job_data_o.byte_cnt  = byte_cnt;
      job_data_o.crc       = crc_i;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= ST_HDR;
         hdr_cnt <= '0;
      end else begin
         case (state)
            ST_HDR: begin
               if (in_fire) begin
                  if (hdr_cnt == HDR_CNT_W'(`HDR_WORDS - 1)) begin
                     hdr_cnt <= '0;
                     state   <= ST_PAYLOAD;
                  end else begin
                     hdr_cnt <= hdr_cnt + 1'b1;
                  end
               end
            end
            ST_PAYLOAD: begin
               if (in_fire && in_beat_i.eop) begin
                  state <= ST_DESC;
               end
            end
            default: begin
               // Descriptor goes out once the job FIFO has room
               if (!job_full_i) begin
                  state <= ST_HDR;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_HDR) begin
         byte_cnt <= '0;
         if (in_fire) begin
            case (hdr_cnt)
               HDR_CNT_W'(`HDR_FLAGS_WORD): flags_q <= flags_word.flags;
               HDR_CNT_W'(`HDR_LEN_WORD):   len_q   <= in_beat_i.data;
               HDR_CNT_W'(`HDR_TASK_WORD):  task_q  <= task_word.task_idx;
               default: ;
            endcase
         end
      end else if (beat_push_o) begin
         byte_cnt <= byte_cnt + (in_beat_i.eop ? `DATA_W'(rem_bytes(in_beat_i.rem))
                                               : `DATA_W'(4));
      end
   end

endmodule

// File: source/payload_crc.sv
`timescale 1ns/100ps
`include "copy_params.svh"

module payload_crc
   import ll_frame_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               clear_i,
   input  logic               enable_i,
   input  logic [`DATA_W-1:0] word_i,
   input  logic [`REM_W-1:0]  rem_i,
   output logic [`DATA_W-1:0] crc_o
);
   logic [`DATA_W-1:0] crc_q;
   logic [`DATA_W-1:0] masked;

   // One bit per step, word MSB first
   function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [31:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 31; i >= 0; i--) begin
         if (c[31] ^ data[i]) begin
            c = (c << 1) ^ `CRC_POLY;
         end else begin
            c = c << 1;
         end
      end
      return c;
   endfunction

   // Drop the low bytes the rem does not cover
   always_comb begin
      masked = '0;
      for (int b = 0; b < `DATA_W/8; b++) begin
         if (b < int'(rem_bytes(rem_i))) begin
            masked[`DATA_W-1-8*b -: 8] = word_i[`DATA_W-1-8*b -: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || clear_i) begin
         crc_q <= `CRC_INIT;
      end else if (enable_i) begin
         crc_q <= crc_step(crc_q, masked);
      end
   end

   assign crc_o = crc_q;

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push_i,
   input  item_t push_data_i,
   output logic  full_o,
   input  logic  pop_i,
   output item_t pop_data_o,
   output logic  empty_o
);
   localparam int PTR_W = $clog2(DEPTH);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   assign full_o     = (count == (PTR_W+1)'(DEPTH));
   assign empty_o    = (count == '0);
   assign do_push    = push_i && !full_o;
   assign do_pop     = pop_i && !empty_o;
   assign pop_data_o = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
      end
   end

endmodule

// File: source/copy_job_pkg.sv
`include "copy_params.svh"

package copy_job_pkg;

   // Bits 31:29 of header word 4
   typedef struct packed {
      logic compress;
      logic decompress;
      logic copy;
   } op_flags_t;

   typedef struct packed {
      op_flags_t          flags;
      logic [`DATA_W-4:0] rsvd;
   } hdr_flags_word_t;

   typedef struct packed {
      logic [`DATA_W-`TASK_W-1:0] rsvd;
      logic [`TASK_W-1:0]         task_idx;
   } hdr_task_word_t;

   // Per-frame descriptor, 109 bits
   typedef struct packed {
      op_flags_t          flags;
      logic [`DATA_W-1:0] len_field;
      logic [`TASK_W-1:0] task_idx;
      logic [`DATA_W-1:0] byte_cnt;
      logic [`DATA_W-1:0] crc;
   } copy_job_t;

   // Completion word 1
   typedef struct packed {
      op_flags_t   flags;
      logic        len_err;
      logic [16:0] rsvd;
      logic        crc_valid;
      logic [9:0]  crc_lo;
   } status1_t;

   // Completion word 3
   typedef struct packed {
      logic [`DATA_W-`TASK_W-1:0] crc_hi;
      logic [`TASK_W-1:0]         task_idx;
   } status3_t;

endpackage

// File: source/ll_frame_pkg.sv
`include "copy_params.svh"

package ll_frame_pkg;

   // One LocalLink beat, 40 bits
   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic [`REM_W-1:0]  rem;
      logic               sof;
      logic               eof;
      logic               sop;
      logic               eop;
   } ll_beat_t;

   // All four bytes valid
   localparam logic [`REM_W-1:0] REM_FULL = 4'b0000;

   // Valid bytes are the high bytes of the word
   function automatic logic [2:0] rem_bytes(input logic [`REM_W-1:0] rem);
      case (rem)
         4'b0001: return 3'd3;
         4'b0011: return 3'd2;
         4'b0111: return 3'd1;
         default: return 3'd4;
      endcase
   endfunction

endpackage

// File: source/copy_params.svh
`ifndef COPY_PARAMS_SVH
`define COPY_PARAMS_SVH

// Frame beat widths
`define DATA_W 32
`define REM_W 4

// Input header layout
`define HDR_WORDS 8
`define HDR_FLAGS_WORD 4
`define HDR_LEN_WORD 5
`define HDR_TASK_WORD 6
`define TASK_W 10

`define STATUS_WORDS 4

`define BEAT_FIFO_DEPTH 16
`define JOB_FIFO_DEPTH 4

// CRC-32, MSB first, no final xor
`define CRC_POLY 32'h04C1_1DB7
`define CRC_INIT 32'hFFFF_FFFF

`endif
